//--- all.f
+incdir+verification
logic/lsu_pkg.sv
logic/ls_address_gen.sv
logic/ls_exception.sv
logic/ls_queue.sv
logic/local_data_mem.sv
logic/load_writeback.sv
logic/load_store_unit.sv
verification/lsu_tb.sv

//--- logic/load_store_unit.sv
`default_nettype none

module load_store_unit (
    input  logic                    clk,
    input  logic                    rst,

    // Request side
    input  logic                    request_valid,
    input  lsu_pkg::ls_request_t    request,
    output logic                    ready,

    // Load results
    output logic                    result_done,
    output lsu_pkg::load_result_t   result,

    // Misalignment exception
    output logic                    exception_valid,
    output lsu_pkg::ls_exception_t  exception,
    input  logic                    exception_ack
);
    import lsu_pkg::*;

    logic take;
    logic push;
    logic misaligned;
    logic [DATA_W-1:0] fault_addr;
    logic queue_full;
    logic pop_valid;
    mem_request_t new_entry;
    mem_request_t head_entry;
    logic [DATA_W-1:0] read_data;

    //////////////////////////////////////////////////////////////////////
    // Handshake
    // Held exception blocks new requests until acknowledged
    assign ready = ~queue_full & ~exception_valid;
    assign take = request_valid & ready;

    //////////////////////////////////////////////////////////////////////
    // Address generation and fault capture
    ls_address_gen address_gen_i (
        .clk        (clk),
        .rst        (rst),
        .take       (take),
        .request    (request),
        .push       (push),
        .entry      (new_entry),
        .misaligned (misaligned),
        .fault_addr (fault_addr)
    );

    ls_exception exception_i (
        .clk             (clk),
        .rst             (rst),
        .raise           (misaligned),
        .fault_addr      (fault_addr),
        .op              (request.op),
        .id              (request.id),
        .ack             (exception_ack),
        .exception_valid (exception_valid),
        .exception       (exception)
    );

    //////////////////////////////////////////////////////////////////////
    // Queue, memory and load return
    ls_queue queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .entry_in  (new_entry),
        .full      (queue_full),
        .pop_valid (pop_valid),
        .entry_out (head_entry)
    );

    local_data_mem mem_i (
        .clk       (clk),
        .valid     (pop_valid),
        .entry     (head_entry),
        .read_data (read_data)
    );

    load_writeback writeback_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (pop_valid),
        .entry       (head_entry),
        .read_data   (read_data),
        .result_done (result_done),
        .result      (result)
    );

endmodule

`default_nettype wire

//--- logic/load_writeback.sv
`default_nettype none

module load_writeback (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  lsu_pkg::mem_request_t       entry,
    input  logic [lsu_pkg::DATA_W-1:0]  read_data,
    output logic                        result_done,
    output lsu_pkg::load_result_t       result
);
    import lsu_pkg::*;

    logic load_issue;
    logic [ID_W-1:0] id_r;
    logic [1:0] byte_addr_r;
    ls_op_t op_r;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic [DATA_W-1:0] load_data;

    assign load_issue = issue & entry.load;

    //////////////////////////////////////////////////////////////////////
    // Attributes travel alongside the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            result_done <= 1'b0;
        end else begin
            result_done <= load_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (load_issue) begin
            id_r <= entry.id;
            byte_addr_r <= entry.byte_addr;
            op_r <= entry.op;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lane select and extension
    // Aligned accesses only, so halfword sits at bit 0 or 16
    assign byte_sel = read_data[byte_addr_r*8 +: 8];
    assign half_sel = byte_addr_r[1] ? read_data[31:16] : read_data[15:0];

    always_comb begin
        case (op_r)
            LB:      load_data = {{(DATA_W-8){byte_sel[7]}}, byte_sel};
            LBU:     load_data = {{(DATA_W-8){1'b0}}, byte_sel};
            LH:      load_data = {{(DATA_W-16){half_sel[15]}}, half_sel};
            LHU:     load_data = {{(DATA_W-16){1'b0}}, half_sel};
            default: load_data = read_data;
        endcase
    end

    assign result = '{id: id_r, data: load_data};

    done_follows_load: assert property (
        @(posedge clk) disable iff (rst) result_done |-> $past(issue && entry.load)
    ) else $error("Load result without an issued load");

endmodule

`default_nettype wire

//--- logic/local_data_mem.sv
`default_nettype none

module local_data_mem (
    input  logic                        clk,
    input  logic                        valid,
    input  lsu_pkg::mem_request_t       entry,
    output logic [lsu_pkg::DATA_W-1:0]  read_data
);
    import lsu_pkg::*;

    logic [3:0][7:0] ram [MEM_WORDS];
    logic write_en;
    logic read_en;

    assign write_en = valid & entry.store;
    assign read_en = valid & entry.load;

    //////////////////////////////////////////////////////////////////////
    // Byte lane writes
    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (entry.be[lane]) begin
                    ram[entry.word_index][lane] <= entry.write_data[lane*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered read, one cycle
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= DATA_W'(ram[entry.word_index]);
        end
    end

endmodule

`default_nettype wire

//--- logic/ls_address_gen.sv
`default_nettype none

module ls_address_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        take,
    input  lsu_pkg::ls_request_t        request,
    output logic                        push,
    output lsu_pkg::mem_request_t       entry,
    output logic                        misaligned,
    output logic [lsu_pkg::DATA_W-1:0]  fault_addr
);
    import lsu_pkg::*;

    logic [DATA_W-1:0] address;
    logic is_store;
    logic is_byte;
    logic is_half;
    logic is_word;
    logic unaligned;
    logic [3:0] be;
    logic [DATA_W-1:0] lane_data;

    //////////////////////////////////////////////////////////////////////
    // Address and width decode
    assign address = request.base
                    + {{(DATA_W-OFFSET_W){request.offset[OFFSET_W-1]}}, request.offset};

    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        case (request.op)
            LB, LBU, SB: is_byte = 1'b1;
            LH, LHU, SH: is_half = 1'b1;
            default:     is_word = 1'b1;
        endcase
    end

    assign is_store = request.op[3];

    // Half needs bit 0 clear, word needs both low bits clear
    assign unaligned = (is_half & address[0]) | (is_word & (|address[1:0]));

    //////////////////////////////////////////////////////////////////////
    // Byte enables, stores only
    always_comb begin
        be = '0;
        if (is_store) begin
            if (is_byte) begin
                be[address[1:0]] = 1'b1;
            end else if (is_half) begin
                be[{address[1], 1'b0}] = 1'b1;
                be[{address[1], 1'b1}] = 1'b1;
            end else begin
                be = '1;
            end
        end
    end

    // Replicate store data across every lane it may land on
    assign lane_data = is_byte ? {4{request.store_data[7:0]}} :
                       is_half ? {2{request.store_data[15:0]}} :
                                 request.store_data;

    assign entry = '{
        word_index: address[MEM_ADDR_W+1:2],
        be:         be,
        write_data: lane_data,
        load:       ~is_store,
        store:      is_store,
        byte_addr:  address[1:0],
        op:         request.op,
        id:         request.id
    };

    assign push = take & ~unaligned;
    assign misaligned = take & unaligned;
    assign fault_addr = address;

    load_without_write_enables: assert property (
        @(posedge clk) disable iff (rst) (push && entry.load) |-> (entry.be == '0)
    ) else $error("Load pushed with byte enables set");

endmodule

`default_nettype wire

//--- logic/ls_exception.sv
`default_nettype none

module ls_exception (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        raise,
    input  logic [lsu_pkg::DATA_W-1:0]  fault_addr,
    input  lsu_pkg::ls_op_t             op,
    input  logic [lsu_pkg::ID_W-1:0]    id,
    input  logic                        ack,
    output logic                        exception_valid,
    output lsu_pkg::ls_exception_t      exception
);
    import lsu_pkg::*;

    logic capture;

    // First fault wins while one is pending
    assign capture = raise & ~exception_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            exception_valid <= 1'b0;
        end else begin
            exception_valid <= (exception_valid & ~ack) | raise;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            exception.code <= op[3] ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
            exception.tval <= fault_addr;
            exception.id <= id;
        end
    end

    held_until_ack: assert property (
        @(posedge clk) disable iff (rst) (exception_valid && !ack) |=> exception_valid
    ) else $error("Exception dropped without acknowledge");

endmodule

`default_nettype wire

//--- logic/ls_queue.sv
`default_nettype none

module ls_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  lsu_pkg::mem_request_t   entry_in,
    output logic                    full,
    output logic                    pop_valid,
    output lsu_pkg::mem_request_t   entry_out
);
    import lsu_pkg::*;

    mem_request_t entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_COUNT_W-1:0] count;

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
        return (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= entry_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    // Memory never stalls, so the head leaves every cycle it is valid
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop_valid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == QUEUE_COUNT_W'(QUEUE_DEPTH));
    assign pop_valid = (count != '0);
    assign entry_out = entries[rd_ptr];

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("Push into full request queue");

    count_in_range: assert property (
        @(posedge clk) disable iff (rst) count <= QUEUE_COUNT_W'(QUEUE_DEPTH)
    ) else $error("Request queue count out of range");

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and sizes
    localparam int DATA_W = 32;
    localparam int OFFSET_W = 12;
    localparam int ID_W = 4;

    // Word index is address bits 9:2, upper bits wrap
    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_W = 8;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_W = $clog2(QUEUE_DEPTH + 1);

    //////////////////////////////////////////////////////////////////////
    // Opcodes and exception codes
    // Bit 3 marks a store, bits 2:0 are the fn3 field
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } ls_op_t;

    // Standard RISC-V mcause values
    typedef enum logic [3:0] {
        LOAD_ADDR_MISALIGNED  = 4'd4,
        STORE_ADDR_MISALIGNED = 4'd6
    } exc_code_t;

    //////////////////////////////////////////////////////////////////////
    // Packets
    typedef struct packed {
        ls_op_t              op;
        logic [DATA_W-1:0]   base;
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]   store_data;
        logic [ID_W-1:0]     id;
    } ls_request_t;

    // Queue entry, write data already on its byte lanes
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] word_index;
        logic [3:0]            be;
        logic [DATA_W-1:0]     write_data;
        logic                  load;
        logic                  store;
        logic [1:0]            byte_addr;
        ls_op_t                op;
        logic [ID_W-1:0]       id;
    } mem_request_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } load_result_t;

    typedef struct packed {
        exc_code_t         code;
        logic [DATA_W-1:0] tval;
        logic [ID_W-1:0]   id;
    } ls_exception_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the load/store unit testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module lsu_tb -f all.f -o lsu_sim \
    && ./obj_dir/lsu_sim \
    || { echo "Simulation run failed"; exit 1; }

//--- verification/lsu_tb_model.svh
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// Model memory, filled by the SW pass before any load reads it
logic [DATA_W-1:0] model_mem [MEM_WORDS];

function automatic logic is_store_op(input ls_op_t op);
    return (op == SB) || (op == SH) || (op == SW);
endfunction

function automatic logic bad_alignment(input ls_op_t op, input logic [DATA_W-1:0] addr);
    logic bad;
    case (op)
        LH, LHU, SH: bad = addr[0];
        LW, SW:      bad = (addr[1:0] != 2'b00);
        default:     bad = 1'b0;
    endcase
    return bad;
endfunction

function automatic load_result_t expected_load(input ls_op_t op, input logic [DATA_W-1:0] addr,
                                               input logic [ID_W-1:0] id);
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] shifted;
    load_result_t res;
    word = model_mem[addr[MEM_ADDR_W+1:2]];
    shifted = word >> (8 * addr[1:0]);
    res.id = id;
    case (op)
        LB:      res.data = {{24{shifted[7]}}, shifted[7:0]};
        LBU:     res.data = {24'h000000, shifted[7:0]};
        LH:      res.data = {{16{shifted[15]}}, shifted[15:0]};
        LHU:     res.data = {16'h0000, shifted[15:0]};
        default: res.data = word;
    endcase
    return res;
endfunction

function automatic ls_exception_t expected_exception(input ls_op_t op,
                                                     input logic [DATA_W-1:0] addr,
                                                     input logic [ID_W-1:0] id);
    ls_exception_t exc;
    exc.code = is_store_op(op) ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
    exc.tval = addr;
    exc.id = id;
    return exc;
endfunction

// Merge the stored bytes into the model word
function automatic void model_store(input ls_op_t op, input logic [DATA_W-1:0] addr,
                                    input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] word;
    word = model_mem[addr[MEM_ADDR_W+1:2]];
    case (op)
        SB:      word[8*addr[1:0] +: 8] = data[7:0];
        SH:      word[16*addr[1] +: 16] = data[15:0];
        default: word = data;
    endcase
    model_mem[addr[MEM_ADDR_W+1:2]] = word;
endfunction

`endif

//--- verification/lsu_tb.sv
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    // About 3000 requests, mostly one cycle each, misaligned ones up to 10
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk;
    logic rst;
    logic request_valid;
    ls_request_t request;
    logic ready;
    logic result_done;
    load_result_t result;
    logic exception_valid;
    ls_exception_t exception;
    logic exception_ack;

    integer seed;
    logic [ID_W-1:0] next_id;
    int cycle_count = 0;
    logic exc_seen = 1'b0;
    load_result_t exp_result;
    ls_exception_t exp_exc;
    load_result_t exp_results [$];
    ls_exception_t exp_exceptions [$];

    ls_op_t all_ops [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
    ls_op_t bad_ops [8] = '{LH, LHU, LW, LW, LW, SH, SH, SW};
    logic [1:0] bad_low [8] = '{2'd1, 2'd3, 2'd1, 2'd2, 2'd3, 2'd1, 2'd3, 2'd2};

`include "lsu_tb_model.svh"

    load_store_unit dut_i (
        .clk             (clk),
        .rst             (rst),
        .request_valid   (request_valid),
        .request         (request),
        .ready           (ready),
        .result_done     (result_done),
        .result          (result),
        .exception_valid (exception_valid),
        .exception       (exception),
        .exception_ack   (exception_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_result(input load_result_t got, input load_result_t exp);
        if (got !== exp) begin
            abort_run($sformatf(
                "CHECK FAILED result: got id 0x%h data 0x%h, expected id 0x%h data 0x%h",
                got.id, got.data, exp.id, exp.data));
        end
    endtask

    task automatic check_exception(input ls_exception_t got, input ls_exception_t exp);
        if (got !== exp) begin
            abort_run($sformatf(
                "CHECK FAILED exception: got 0x%h/0x%h/0x%h expected 0x%h/0x%h/0x%h",
                got.code, got.tval, got.id, exp.code, exp.tval, exp.id));
        end
    endtask

    function automatic logic [DATA_W-1:0] force_aligned(input ls_op_t op,
                                                        input logic [DATA_W-1:0] addr);
        logic [DATA_W-1:0] a;
        a = addr;
        case (op)
            LH, LHU, SH: a[0] = 1'b0;
            LW, SW:      a[1:0] = 2'b00;
            default:     a = addr;
        endcase
        return a;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // One request, called on a falling edge, returns on the next one
    task automatic send(input ls_op_t op, input logic [DATA_W-1:0] addr,
                        input logic [DATA_W-1:0] data);
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0] base;
        logic fault;
        int delay;
        offset = OFFSET_W'($random(seed));
        base = addr - {{(DATA_W-OFFSET_W){offset[OFFSET_W-1]}}, offset};
        fault = bad_alignment(op, addr);
        while (!ready) begin
            @(negedge clk);
        end
        request = '{op: op, base: base, offset: offset, store_data: data, id: next_id};
        request_valid = 1'b1;
        if (fault) begin
            exp_exceptions.push_back(expected_exception(op, addr, next_id));
        end else if (is_store_op(op)) begin
            model_store(op, addr, data);
        end else begin
            exp_results.push_back(expected_load(op, addr, next_id));
        end
        next_id = next_id + 1'b1;
        @(negedge clk);
        request_valid = 1'b0;
        if (fault) begin
            check_flag("exception_valid", exception_valid, 1'b1);
            delay = int'(3'($random(seed)));
            repeat (delay) begin
                check_flag("ready", ready, 1'b0);
                @(negedge clk);
            end
            check_flag("ready", ready, 1'b0);
            exception_ack = 1'b1;
            @(negedge clk);
            exception_ack = 1'b0;
            check_flag("exception_valid", exception_valid, 1'b0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        int i;
        int b;
        logic [DATA_W-1:0] rnd;
        logic [7:0] w;
        logic [DATA_W-1:0] addr;
        ls_op_t op;
        seed = 32'hfaeecde9;
        rst = 1'b1;
        request_valid = 1'b0;
        request = '0;
        exception_ack = 1'b0;
        next_id = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_flag("ready", ready, 1'b1);
        check_flag("result_done", result_done, 1'b0);
        check_flag("exception_valid", exception_valid, 1'b0);

        // Fill every word, then read each back
        for (i = 0; i < MEM_WORDS; i++) begin
            rnd = $random(seed);
            send(SW, {rnd[31:10], i[7:0], 2'b00}, $random(seed));
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            rnd = $random(seed);
            send(LW, {rnd[31:10], i[7:0], 2'b00}, '0);
        end

        // Narrow loads at every legal offset
        for (i = 0; i < 32; i++) begin
            rnd = $random(seed);
            w = 8'($random(seed));
            for (b = 0; b < 4; b++) begin
                send(LB, {rnd[31:10], w, b[1:0]}, '0);
                send(LBU, {rnd[31:10], w, b[1:0]}, '0);
                if (!b[0]) begin
                    send(LH, {rnd[31:10], w, b[1:0]}, '0);
                    send(LHU, {rnd[31:10], w, b[1:0]}, '0);
                end
            end
        end

        // Partial stores merged into whole words
        for (i = 0; i < 32; i++) begin
            rnd = $random(seed);
            w = 8'($random(seed));
            send(SB, {rnd[31:10], w, rnd[1:0]}, $random(seed));
            send(SH, {rnd[31:10], w, rnd[2], 1'b0}, $random(seed));
            send(LW, {rnd[31:10], w, 2'b00}, '0);
        end

        // Misaligned accesses, each followed by a check of the word
        for (i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send(bad_ops[i], {rnd[31:10], rnd[9:2], bad_low[i]}, $random(seed));
            send(LW, {rnd[31:10], rnd[9:2], 2'b00}, '0);
        end

        // Random back to back stream, about one in sixteen left unaligned
        for (i = 0; i < 2000; i++) begin
            op = all_ops[3'($random(seed))];
            addr = $random(seed);
            if (4'($random(seed)) != 4'd0) begin
                addr = force_aligned(op, addr);
            end
            send(op, addr, $random(seed));
        end

        // Longest drain is a full queue ahead of the last load plus the read
        repeat (QUEUE_DEPTH + 4) @(negedge clk);
        if (exp_results.size() == 0 && exp_exceptions.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("Expected results or exceptions were never delivered");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (result_done) begin
                if (exp_results.size() == 0) begin
                    abort_run("Load result arrived with no load outstanding");
                end else begin
                    exp_result = exp_results.pop_front();
                    check_result(result, exp_result);
                end
            end
            if (exception_valid && !exc_seen) begin
                if (exp_exceptions.size() == 0) begin
                    abort_run("Exception raised for an aligned request");
                end else begin
                    exp_exc = exp_exceptions.pop_front();
                    check_exception(exception, exp_exc);
                end
            end
            exc_seen = exception_valid;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout waiting for the unit to finish");
        end
    end

endmodule

`default_nettype wire
